// ==== hw/video_timing_pkg.sv ====
package video_timing_pkg;

    // ******************************************************************
    // Character grid
    // ******************************************************************

    localparam int TEXT_COLS = 80;
    localparam int TEXT_ROWS = 40;
    localparam int TEXT_CELLS = TEXT_COLS * TEXT_ROWS; // 3200 cells in the text region.

    localparam int CHAR_W = 8;
    localparam int CHAR_H = 12;

    // ******************************************************************
    // 640 by 480 VGA timing, one pixel per clock
    // ******************************************************************

    localparam int H_VISIBLE = 640;
    localparam int H_FRONT = 16;
    localparam int H_SYNC = 96;
    localparam int H_BACK = 48;
    localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK; // 800 cycles per line.

    localparam int V_VISIBLE = 480;
    localparam int V_FRONT = 10;
    localparam int V_SYNC = 2;
    localparam int V_BACK = 33;
    localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK; // 525 lines per frame.

    localparam int HCOUNT_W = 10;
    localparam int VCOUNT_W = 10;

endpackage

// ==== hw/host_map_pkg.sv ====
package host_map_pkg;

    localparam int BUS_ADDR_W = 16;
    localparam int BUS_DATA_W = 8;
    localparam int MEM_ADDR_W = 13;

    // ******************************************************************
    // Address map
    // ******************************************************************

    // Host addresses below this go to the video memory.
    localparam logic [BUS_ADDR_W-1:0] MEM_TOP = 16'h1C00;

    localparam logic [MEM_ADDR_W-1:0] TEXT_BASE = 13'h0000; // Row times 80 plus column.
    localparam logic [MEM_ADDR_W-1:0] FONT_BASE = 13'h1000; // Code times 12 plus glyph row.

    localparam logic [BUS_ADDR_W-1:0] CTL_ADDR = 16'h1FFF;
    localparam logic [BUS_ADDR_W-1:0] CRX_ADDR = 16'h1FFE;
    localparam logic [BUS_ADDR_W-1:0] CRY_ADDR = 16'h1FFD;

    localparam int CRX_W = 7;
    localparam int CRY_W = 6;

    // ******************************************************************
    // Control register layout
    // ******************************************************************

    localparam logic [BUS_DATA_W-1:0] CTL_DEFAULT = 8'b1111_1000; // White on black.

    localparam int CTL_ENABLE_BIT = 7;
    localparam int CTL_CURSOR_BIT = 6;
    localparam int CTL_FG_R = 5;
    localparam int CTL_FG_G = 4;
    localparam int CTL_FG_B = 3;
    localparam int CTL_BG_R = 2;
    localparam int CTL_BG_G = 1;
    localparam int CTL_BG_B = 0;

    localparam int CURSOR_LINE_FIRST = 10; // Underline covers rows 10 and 11.

endpackage

// ==== hw/host_regs.sv ====
module host_regs (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 strobe,
    input  logic                                 rw,
    input  logic [host_map_pkg::BUS_ADDR_W-1:0]  addr,
    input  logic [host_map_pkg::BUS_DATA_W-1:0]  d_in,
    input  logic [host_map_pkg::BUS_DATA_W-1:0]  mem_rdata,
    output logic [host_map_pkg::BUS_DATA_W-1:0]  d_out,
    output logic                                 mem_en,
    output logic                                 mem_we,
    output logic [host_map_pkg::MEM_ADDR_W-1:0]  mem_addr,
    output logic [host_map_pkg::BUS_DATA_W-1:0]  mem_wdata,
    output logic [host_map_pkg::BUS_DATA_W-1:0]  vga_ctl,
    output logic [host_map_pkg::CRX_W-1:0]       cursor_col,
    output logic [host_map_pkg::CRY_W-1:0]       cursor_row
);
    import host_map_pkg::*;

    logic                  in_mem;
    logic [BUS_DATA_W-1:0] reg_value;
    logic [BUS_DATA_W-1:0] rd_hold;
    logic                  rd_from_mem;

    assign in_mem = addr < MEM_TOP;

    // The memory sees the bus directly, so a write lands on the strobe edge.
    assign mem_en = strobe && in_mem;
    assign mem_we = rw;
    assign mem_addr = addr[MEM_ADDR_W-1:0];
    assign mem_wdata = d_in;

    // ******************************************************************
    // Registers
    // ******************************************************************

    always_comb begin
        case (addr)
            CTL_ADDR: reg_value = vga_ctl;
            CRX_ADDR: reg_value = BUS_DATA_W'(cursor_col);
            CRY_ADDR: reg_value = BUS_DATA_W'(cursor_row);
            default:  reg_value = '0; // Memory and unmapped space.
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vga_ctl <= CTL_DEFAULT;
            cursor_col <= '0;
            cursor_row <= '0;
        end else if (strobe && rw) begin
            case (addr)
                CTL_ADDR: vga_ctl <= d_in;
                CRX_ADDR: cursor_col <= d_in[CRX_W-1:0];
                CRY_ADDR: cursor_row <= d_in[CRY_W-1:0];
                default:  ; // Memory writes go through port B, others are dropped.
            endcase
        end
    end

    // ******************************************************************
    // Read return
    // ******************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_from_mem <= 1'b0;
            rd_hold <= '0;
        end else if (strobe && !rw) begin
            rd_from_mem <= in_mem;
            rd_hold <= reg_value;
        end
    end

    // Port B keeps its last read byte, so both sources hold between reads.
    assign d_out = rd_from_mem ? mem_rdata : rd_hold;

endmodule

// ==== hw/text_buffer.sv ====
module text_buffer (
    input  logic                                 clk,
    input  logic [host_map_pkg::MEM_ADDR_W-1:0]  fetch_addr,
    output logic [host_map_pkg::BUS_DATA_W-1:0]  fetch_data,
    input  logic                                 mem_en,
    input  logic                                 mem_we,
    input  logic [host_map_pkg::MEM_ADDR_W-1:0]  mem_addr,
    input  logic [host_map_pkg::BUS_DATA_W-1:0]  mem_wdata,
    output logic [host_map_pkg::BUS_DATA_W-1:0]  mem_rdata
);
    import host_map_pkg::*;
    import video_timing_pkg::*;

    logic [BUS_DATA_W-1:0] ram [0:(1 << MEM_ADDR_W)-1];

    // Blank screen at power up: spaces in the text, an empty font.
    initial begin
        for (int i = 0; i < (1 << MEM_ADDR_W); i++) begin
            if (i >= TEXT_BASE && i < TEXT_BASE + TEXT_CELLS) begin
                ram[i] = 8'h20;
            end else begin
                ram[i] = 8'h00;
            end
        end
    end

    // ******************************************************************
    // Port A, video side
    // ******************************************************************

    always_ff @(posedge clk) begin
        fetch_data <= ram[fetch_addr]; // Read every cycle.
    end

    // ******************************************************************
    // Port B, host side
    // ******************************************************************

    always @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) begin
                ram[mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= ram[mem_addr]; // Only reads update the output.
            end
        end
    end

endmodule

// ==== hw/text_renderer.sv ====
module text_renderer (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [host_map_pkg::BUS_DATA_W-1:0]  vga_ctl,
    input  logic [host_map_pkg::CRX_W-1:0]       cursor_col,
    input  logic [host_map_pkg::CRY_W-1:0]       cursor_row,
    input  logic [host_map_pkg::BUS_DATA_W-1:0]  fetch_data,
    output logic [host_map_pkg::MEM_ADDR_W-1:0]  fetch_addr,
    output logic                                 pixel_r,
    output logic                                 pixel_g,
    output logic                                 pixel_b,
    output logic                                 hsync,
    output logic                                 vsync
);
    import video_timing_pkg::*;
    import host_map_pkg::*;

    logic [HCOUNT_W-1:0]         h_count;
    logic [VCOUNT_W-1:0]         v_count;
    logic [$clog2(CHAR_W)-1:0]   phase;
    logic                        in_tail;
    logic [CRX_W-1:0]            cell_col;
    logic [CRY_W-1:0]            cell_row;
    logic [$clog2(CHAR_H)-1:0]   cell_line;
    logic [BUS_DATA_W-1:0]       code;
    logic [BUS_DATA_W-1:0]       shifter;
    logic [MEM_ADDR_W-1:0]       text_addr;
    logic [MEM_ADDR_W-1:0]       glyph_addr;
    logic                        cursor_hit;
    logic                        pix_on;

    // ******************************************************************
    // Beam counters
    // ******************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == H_TOTAL - 1) begin
            h_count <= '0;
            v_count <= (v_count == V_TOTAL - 1) ? '0 : v_count + 1'b1;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    assign phase = h_count[$clog2(CHAR_W)-1:0];
    assign in_tail = h_count >= H_TOTAL - CHAR_W; // Column 0 of the next line.
    assign cell_col = in_tail ? '0 : CRX_W'(h_count / CHAR_W + 1);

    // Row and glyph line of the line being fetched, one window ahead of the beam.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cell_line <= '0;
            cell_row <= '0;
        end else if (h_count == H_TOTAL - CHAR_W - 1) begin
            if (v_count == V_TOTAL - 1) begin
                cell_line <= '0;
                cell_row <= '0;
            end else if (cell_line == CHAR_H - 1) begin
                cell_line <= '0;
                cell_row <= cell_row + 1'b1;
            end else begin
                cell_line <= cell_line + 1'b1;
            end
        end
    end

    // ******************************************************************
    // Cell fetch and shifter
    // ******************************************************************

    assign text_addr = TEXT_BASE + MEM_ADDR_W'(cell_row * TEXT_COLS) + MEM_ADDR_W'(cell_col);
    assign glyph_addr = FONT_BASE + MEM_ADDR_W'(code * CHAR_H) + MEM_ADDR_W'(cell_line);
    assign fetch_addr = (phase < 2) ? text_addr : glyph_addr; // Glyph byte is ready at phase 7.

    always_ff @(posedge clk) begin
        if (phase == 1) begin
            code <= fetch_data;
        end
    end

    assign cursor_hit = vga_ctl[CTL_CURSOR_BIT] && cell_col == cursor_col &&
                        cell_row == cursor_row && cell_line >= CURSOR_LINE_FIRST;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shifter <= '0;
        end else if (phase == CHAR_W - 1) begin
            shifter <= cursor_hit ? '1 : fetch_data;
        end else begin
            shifter <= shifter << 1; // Leftmost pixel is the MSB.
        end
    end

    // ******************************************************************
    // Output stage
    // ******************************************************************

    assign pix_on = h_count < H_VISIBLE && v_count < V_VISIBLE && vga_ctl[CTL_ENABLE_BIT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pixel_r <= 1'b0;
            pixel_g <= 1'b0;
            pixel_b <= 1'b0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            pixel_r <= pix_on && (shifter[7] ? vga_ctl[CTL_FG_R] : vga_ctl[CTL_BG_R]);
            pixel_g <= pix_on && (shifter[7] ? vga_ctl[CTL_FG_G] : vga_ctl[CTL_BG_G]);
            pixel_b <= pix_on && (shifter[7] ? vga_ctl[CTL_FG_B] : vga_ctl[CTL_BG_B]);
            hsync <= !(h_count >= H_VISIBLE + H_FRONT &&
                       h_count < H_VISIBLE + H_FRONT + H_SYNC);
            vsync <= !(v_count >= V_VISIBLE + V_FRONT &&
                       v_count < V_VISIBLE + V_FRONT + V_SYNC);
        end
    end

endmodule

// ==== hw/vga_text_top.sv ====
module vga_text_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 strobe,
    input  logic                                 rw,
    input  logic [host_map_pkg::BUS_ADDR_W-1:0]  addr,
    input  logic [host_map_pkg::BUS_DATA_W-1:0]  d_in,
    output logic [host_map_pkg::BUS_DATA_W-1:0]  d_out,
    output logic [2:0]                           vga_red,
    output logic [2:0]                           vga_green,
    output logic [1:0]                           vga_blue,
    output logic                                 hsync,
    output logic                                 vsync
);
    import host_map_pkg::*;

    logic                  mem_en;
    logic                  mem_we;
    logic [MEM_ADDR_W-1:0] mem_addr;
    logic [BUS_DATA_W-1:0] mem_wdata;
    logic [BUS_DATA_W-1:0] mem_rdata;
    logic [BUS_DATA_W-1:0] vga_ctl;
    logic [CRX_W-1:0]      cursor_col;
    logic [CRY_W-1:0]      cursor_row;
    logic [MEM_ADDR_W-1:0] fetch_addr;
    logic [BUS_DATA_W-1:0] fetch_data;
    logic                  pixel_r;
    logic                  pixel_g;
    logic                  pixel_b;

    host_regs u_regs (
        .clk        ( clk        ), .rst_n      ( rst_n      ), .strobe    ( strobe    ),
        .rw         ( rw         ), .addr       ( addr       ), .d_in      ( d_in      ),
        .mem_rdata  ( mem_rdata  ), .d_out      ( d_out      ), .mem_en    ( mem_en    ),
        .mem_we     ( mem_we     ), .mem_addr   ( mem_addr   ), .mem_wdata ( mem_wdata ),
        .vga_ctl    ( vga_ctl    ), .cursor_col ( cursor_col ), .cursor_row ( cursor_row )
    );

    text_buffer u_buffer (
        .clk        ( clk        ), .fetch_addr ( fetch_addr ), .fetch_data ( fetch_data ),
        .mem_en     ( mem_en     ), .mem_we     ( mem_we     ), .mem_addr   ( mem_addr   ),
        .mem_wdata  ( mem_wdata  ), .mem_rdata  ( mem_rdata  )
    );

    text_renderer u_renderer (
        .clk        ( clk        ), .rst_n      ( rst_n      ), .vga_ctl    ( vga_ctl    ),
        .cursor_col ( cursor_col ), .cursor_row ( cursor_row ), .fetch_data ( fetch_data ),
        .fetch_addr ( fetch_addr ), .pixel_r    ( pixel_r    ), .pixel_g    ( pixel_g    ),
        .pixel_b    ( pixel_b    ), .hsync      ( hsync      ), .vsync      ( vsync      )
    );

    // One bit per colour drives the whole pin group.
    assign vga_red = {3{pixel_r}};
    assign vga_green = {3{pixel_g}};
    assign vga_blue = {2{pixel_b}};

endmodule

// ==== testbench/tb_vga_text.sv ====
module tb_vga_text;
    timeunit 1ns;
    timeprecision 10ps;

    import video_timing_pkg::*;
    import host_map_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int FONT_BYTES = 256 * CHAR_H;
    localparam int BUS_CYCLES = 2 * (TEXT_CELLS + FONT_BYTES + 200 + 64);
    localparam longint WATCHDOG_NS = longint'(4 * FRAME_CYCLES + BUS_CYCLES) * CLK_PERIOD;
    localparam int TOP_ROWS = 4; // Text rows of the last frame checked with the cursor off.

    logic                  clk;
    logic                  rst_n;
    logic                  strobe;
    logic                  rw;
    logic [BUS_ADDR_W-1:0] addr;
    logic [BUS_DATA_W-1:0] d_in;
    logic [BUS_DATA_W-1:0] d_out;
    logic [2:0]            vga_red;
    logic [2:0]            vga_green;
    logic [1:0]            vga_blue;
    logic                  hsync;
    logic                  vsync;

    logic [BUS_DATA_W-1:0] model [0:(1 << BUS_ADDR_W)-1]; // Whole bus space, unmapped stays 0.
    int                    cycles = 0;
    int                    reset_edges = 0;
    int                    checks = 0;
    int                    errors = 0;

    vga_text_top uut (
        .clk       ( clk       ), .rst_n     ( rst_n     ), .strobe ( strobe ),
        .rw        ( rw        ), .addr      ( addr      ), .d_in   ( d_in   ),
        .d_out     ( d_out     ), .vga_red   ( vga_red   ), .vga_green ( vga_green ),
        .vga_blue  ( vga_blue  ), .hsync     ( hsync     ), .vsync  ( vsync  )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycles <= cycles + 1; // Cycle n shows beam position n - 1.
        end else begin
            reset_edges <= reset_edges + 1;
        end
    end

    function automatic int frame_of();
        return (cycles - 1) / FRAME_CYCLES;
    endfunction

    function automatic int line_of();
        return ((cycles - 1) / H_TOTAL) % V_TOTAL;
    endfunction

    // ******************************************************************
    // Expected colour group and syncs for one beam position
    // ******************************************************************

    function automatic logic [9:0] expected_output(input int h, input int v);
        logic       hs;
        logic       vs;
        logic [7:0] ctl;
        logic [7:0] glyph;
        logic [7:0] colour;
        logic [2:0] rgb;
        int         col;
        int         row;
        int         line;
        int         code;
        hs = !(h >= H_VISIBLE + H_FRONT && h < H_VISIBLE + H_FRONT + H_SYNC);
        vs = !(v >= V_VISIBLE + V_FRONT && v < V_VISIBLE + V_FRONT + V_SYNC);
        ctl = model[CTL_ADDR];
        colour = '0;
        if (h < H_VISIBLE && v < V_VISIBLE && ctl[CTL_ENABLE_BIT]) begin
            col = h / CHAR_W;
            row = v / CHAR_H;
            line = v % CHAR_H;
            code = model[int'(TEXT_BASE) + row * TEXT_COLS + col];
            glyph = model[int'(FONT_BASE) + code * CHAR_H + line];
            if (ctl[CTL_CURSOR_BIT] && col == model[CRX_ADDR] && row == model[CRY_ADDR] &&
                line >= CURSOR_LINE_FIRST) begin
                glyph = 8'hFF; // Underline fills the whole cell width.
            end
            if (glyph[CHAR_W - 1 - h % CHAR_W]) begin
                rgb = {ctl[CTL_FG_R], ctl[CTL_FG_G], ctl[CTL_FG_B]};
            end else begin
                rgb = {ctl[CTL_BG_R], ctl[CTL_BG_G], ctl[CTL_BG_B]};
            end
            colour = {{3{rgb[2]}}, {3{rgb[1]}}, {2{rgb[0]}}};
        end
        return {colour, hs, vs};
    endfunction

    // ******************************************************************
    // Output comparison on the falling edge
    // ******************************************************************

    always @(negedge clk) begin : compare
        logic [9:0] expect_out;
        int         pos;
        int         h;
        int         v;
        int         frame;
        if (!rst_n) begin
            if (reset_edges > 0) begin
                checks++;
                assert (hsync === 1'b1 && vsync === 1'b1 && d_out === 8'h00 &&
                        {vga_red, vga_green, vga_blue} === 8'h00) else begin
                    errors++;
                    $display("Fail reset state: hsync=%h vsync=%h colour=%h d_out=%h",
                             hsync, vsync, {vga_red, vga_green, vga_blue}, d_out);
                end
            end
        end else if (cycles > 0) begin
            pos = cycles - 1;
            h = pos % H_TOTAL;
            v = (pos / H_TOTAL) % V_TOTAL;
            frame = pos / FRAME_CYCLES;
            expect_out = expected_output(h, v);
            checks++;
            assert (hsync === expect_out[1]) else begin
                errors++;
                $display("Fail hsync at h=%0d v=%0d: got %h, expected %h", h, v, hsync,
                         expect_out[1]);
            end
            assert (vsync === expect_out[0]) else begin
                errors++;
                $display("Fail vsync at h=%0d v=%0d: got %h, expected %h", h, v, vsync,
                         expect_out[0]);
            end
            // Frames 1 and 2 in full, then the top of frame 3 with the cursor off.
            if (frame == 1 || frame == 2 || (frame == 3 && v < TOP_ROWS * CHAR_H)) begin
                assert ({vga_red, vga_green, vga_blue} === expect_out[9:2]) else begin
                    errors++;
                    $display("Fail colour at h=%0d v=%0d: got %h, expected %h", h, v,
                             {vga_red, vga_green, vga_blue}, expect_out[9:2]);
                end
            end
        end
    end

    // ******************************************************************
    // Bus tasks
    // ******************************************************************

    task automatic bus_write(input logic [BUS_ADDR_W-1:0] a, input logic [BUS_DATA_W-1:0] d);
        strobe = 1'b1;
        rw = 1'b1;
        addr = a;
        d_in = d;
        if (a < MEM_TOP || a == CTL_ADDR) begin
            model[a] = d;
        end else if (a == CRX_ADDR) begin
            model[a] = BUS_DATA_W'(d[CRX_W-1:0]);
        end else if (a == CRY_ADDR) begin
            model[a] = BUS_DATA_W'(d[CRY_W-1:0]);
        end
        @(negedge clk);
        strobe = 1'b0;
    endtask

    task automatic read_check(input logic [BUS_ADDR_W-1:0] a);
        strobe = 1'b1;
        rw = 1'b0;
        addr = a;
        @(negedge clk);
        strobe = 1'b0;
        checks++;
        assert (d_out === model[a]) else begin
            errors++;
            $display("Fail d_out at addr %h: got %h, expected %h", a, d_out, model[a]);
        end
    endtask

    task automatic wait_for_line(input int frame, input int line);
        while (frame_of() < frame || (frame_of() == frame && line_of() < line)) begin
            @(negedge clk);
        end
    endtask

    // ******************************************************************
    // Stimulus
    // ******************************************************************

    initial begin
        logic [BUS_ADDR_W-1:0] a;
        logic [2:0]            fg;
        void'($urandom(32'h6f47_9170));
        rst_n = 1'b0;
        strobe = 1'b0;
        rw = 1'b0;
        addr = '0;
        d_in = '0;
        for (int i = 0; i < (1 << BUS_ADDR_W); i++) begin
            model[i] = (i < TEXT_CELLS) ? 8'h20 : 8'h00;
        end
        model[CTL_ADDR] = CTL_DEFAULT;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        checks++;
        assert (d_out === 8'h00 && {vga_red, vga_green, vga_blue} === 8'h00) else begin
            errors++;
            $display("Fail after reset: colour=%h d_out=%h",
                     {vga_red, vga_green, vga_blue}, d_out);
        end
        for (int i = 0; i < 8; i++) begin
            bus_write(CTL_ADDR, 8'($urandom));
            read_check(CTL_ADDR);
            bus_write(CRX_ADDR, 8'($urandom));
            read_check(CRX_ADDR);
            bus_write(CRY_ADDR, 8'($urandom));
            read_check(CRY_ADDR);
        end
        for (int i = 0; i < 8; i++) begin
            a = (i % 2 == 0) ? 16'($urandom_range(16'hFFFF, 16'h2000)) :
                               16'($urandom_range(16'h1FFC, 16'h1C00));
            bus_write(a, 8'($urandom));
            read_check(a);
        end
        read_check(CTL_ADDR);
        read_check(CRX_ADDR);
        read_check(CRY_ADDR);
        for (int i = 0; i < TEXT_CELLS; i++) begin
            bus_write(BUS_ADDR_W'(int'(TEXT_BASE) + i), 8'($urandom));
        end
        for (int i = 0; i < FONT_BYTES; i++) begin
            bus_write(BUS_ADDR_W'(int'(FONT_BASE) + i), 8'($urandom));
        end
        for (int i = 0; i < 200; i++) begin
            read_check(16'($urandom_range(int'(MEM_TOP) - 1, 0)));
        end
        fg = 3'($urandom);
        bus_write(CTL_ADDR, {1'b1, 1'b1, fg, ~fg}); // Background is the inverse of foreground.
        bus_write(CRX_ADDR, 8'($urandom_range(TEXT_COLS - 1, 0)));
        // The cursor sits in the rows that the last frame shows with the cursor off.
        bus_write(CRY_ADDR, 8'($urandom_range(TOP_ROWS - 1, 0)));
        assert (frame_of() == 0) else begin
            errors++;
            $display("Bus traffic did not finish within the first frame");
        end
        wait_for_line(1, V_VISIBLE + 20);
        bus_write(CTL_ADDR, model[CTL_ADDR] & ~(8'h1 << CTL_ENABLE_BIT));
        wait_for_line(2, V_VISIBLE + 20);
        bus_write(CTL_ADDR, (model[CTL_ADDR] | (8'h1 << CTL_ENABLE_BIT)) &
                            ~(8'h1 << CTL_CURSOR_BIT));
        wait_for_line(3, TOP_ROWS * CHAR_H);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("The run timed out before the last frame was checked");
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== all.f ====
hw/video_timing_pkg.sv
hw/host_map_pkg.sv
hw/host_regs.sv
hw/text_buffer.sv
hw/text_renderer.sv
hw/vga_text_top.sv
testbench/tb_vga_text.sv

// ==== Bender.yml ====
package:
  name: vga_text

sources:
  # Packages first, then the design from the leaves up.
  - hw/video_timing_pkg.sv
  - hw/host_map_pkg.sv
  - hw/host_regs.sv
  - hw/text_buffer.sv
  - hw/text_renderer.sv
  - hw/vga_text_top.sv

  - target: test
    files:
      - testbench/tb_vga_text.sv
